// File: Makefile
TOP = conv_datapath_front_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: hw/channel_out_buffer.sv
`timescale 1ns/1ps

module channel_out_buffer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  conv_pkg::result_t                     res,
    input  logic                                  res_valid,
    input  logic                                  channel_out_en,
    input  logic                                  channel_out_reset,
    output logic                                  out_valid,
    output logic [conv_pkg::col_width-1:0]        out_index,
    output logic signed [conv_pkg::acc_width-1:0] out_value
);

    logic signed [conv_pkg::acc_width-1:0] mem [conv_pkg::row_len];
    logic [conv_pkg::col_width:0] count;   // entries written this run
    logic [conv_pkg::col_width:0] rd_ptr;  // next entry to drain
    logic                         rd_ok;

    assign rd_ok = channel_out_en && (rd_ptr < count);

    // results land at their own index
    always_ff @(posedge clk) begin
        if (res_valid) begin
            mem[res.index] <= res.value;
        end
    end

    ////////////////////////////////////////////////////////////
    // count and drain pointer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_ok;
            if (start) begin
                count  <= '0;  // new row, old results gone
                rd_ptr <= '0;
            end else begin
                if (res_valid) begin
                    count <= count + (conv_pkg::col_width+1)'(1);
                end
                if (channel_out_reset) begin
                    rd_ptr <= '0;  // restart drain at index 0
                end else if (rd_ok) begin
                    rd_ptr <= rd_ptr + (conv_pkg::col_width+1)'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ok) begin
            out_index <= rd_ptr[conv_pkg::col_width-1:0];
            out_value <= mem[rd_ptr[conv_pkg::col_width-1:0]];
        end
    end

endmodule

// File: hw/conv_datapath_front.sv
`timescale 1ns/1ps

module conv_datapath_front (
    input  logic                                  clk,
    input  logic                                  rst,
    input  conv_pkg::conv_cfg_t                   cfg,
    input  logic                                  en,
    input  conv_pkg::pix_wr_t                     pix_wr,
    input  logic                                  pix_we,
    input  conv_pkg::wgt_wr_t                     wgt_wr,
    input  logic                                  wgt_we,
    input  logic                                  channel_out_en,
    input  logic                                  channel_out_reset,
    output logic                                  busy,
    output logic                                  done,
    output logic                                  out_valid,
    output logic [conv_pkg::col_width-1:0]        out_index,
    output logic signed [conv_pkg::acc_width-1:0] out_value
);

    logic                           rd_en;
    logic [conv_pkg::col_width-1:0] rd_col;
    logic [conv_pkg::col_width-1:0] rd_index;
    conv_pkg::conv_cfg_t            cfg_q;
    conv_pkg::window_t              window;
    logic                           win_valid;
    conv_pkg::result_t              res;
    logic                           res_valid;
    logic                           start;  // first read of a run

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////
    window_sequencer i_window_sequencer (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .cfg       (cfg),
        .res_valid (res_valid),  // writebacks close the run
        .rd_en     (rd_en),
        .rd_col    (rd_col),
        .rd_index  (rd_index),
        .cfg_q     (cfg_q),
        .busy      (busy),
        .done      (done),
        .start     (start)
    );

    line_buffers i_line_buffers (
        .clk       (clk),
        .rst       (rst),
        .pix_we    (pix_we),
        .pix_wr    (pix_wr),
        .busy      (busy),
        .rd_en     (rd_en),
        .rd_col    (rd_col),
        .window    (window),
        .win_valid (win_valid)
    );

    ////////////////////////////////////////////////////////////
    // compute and output side
    ////////////////////////////////////////////////////////////
    mac_array i_mac_array (
        .clk       (clk),
        .rst       (rst),
        .wgt_we    (wgt_we),
        .wgt_wr    (wgt_wr),
        .busy      (busy),
        .window    (window),
        .win_valid (win_valid),
        .k         (cfg_q.k),
        .rd_index  (rd_index),
        .res       (res),
        .res_valid (res_valid)
    );

    channel_out_buffer i_channel_out_buffer (
        .clk               (clk),
        .rst               (rst),
        .start             (start),
        .res               (res),
        .res_valid         (res_valid),
        .channel_out_en    (channel_out_en),
        .channel_out_reset (channel_out_reset),
        .out_valid         (out_valid),
        .out_index         (out_index),
        .out_value         (out_value)
    );

endmodule

// File: hw/conv_pkg.sv
package conv_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////
    localparam int row_len      = 32;             // pixels per line buffer
    localparam int buffers_num  = 3;              // line buffers, also max kernel size
    localparam int pixel_width  = 8;              // unsigned pixels
    localparam int weight_width = 8;              // signed weights
    localparam int headroom     = 4;              // guard bits on the sum
    localparam int acc_width    = 16 + headroom;  // 9 taps of 255 * -128 still fit
    localparam int col_width    = 5;              // column / output index

    ////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////

    // run config, latched on start
    typedef struct packed {
        logic [1:0]           k;   // kernel size 1..3
        logic [1:0]           s;   // stride 1 or 2
        logic [col_width:0]   ox;  // outputs per row, up to 32
    } conv_cfg_t;

    // one pixel write
    typedef struct packed {
        logic [1:0]             row;
        logic [col_width-1:0]   col;
        logic [pixel_width-1:0] data;
    } pix_wr_t;

    // one weight write
    typedef struct packed {
        logic [1:0]                     row;
        logic [1:0]                     col;
        logic signed [weight_width-1:0] data;
    } wgt_wr_t;

    // 3x3 window, pix[row][col]
    typedef struct packed {
        logic [buffers_num-1:0][buffers_num-1:0][pixel_width-1:0] pix;
    } window_t;

    // one computed output pixel
    typedef struct packed {
        logic [col_width-1:0]        index;
        logic signed [acc_width-1:0] value;
    } result_t;

    // sequencer states
    typedef enum logic [1:0] {
        seq_idle,
        seq_run,
        seq_flush
    } seq_state_t;

endpackage

// File: hw/line_buffers.sv
`timescale 1ns/1ps

module line_buffers (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           pix_we,
    input  conv_pkg::pix_wr_t              pix_wr,
    input  logic                           busy,
    input  logic                           rd_en,
    input  logic [conv_pkg::col_width-1:0] rd_col,
    output conv_pkg::window_t              window,
    output logic                           win_valid
);

    // three row memories
    logic [conv_pkg::pixel_width-1:0] mem [conv_pkg::buffers_num][conv_pkg::row_len];

    // window column per tap, spare msb flags col >= 32
    logic [conv_pkg::col_width:0] tap_col [conv_pkg::buffers_num];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        // frozen while a run reads the rows
        if (pix_we && !busy && (pix_wr.row < 2'(conv_pkg::buffers_num))) begin
            mem[pix_wr.row][pix_wr.col] <= pix_wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // window read
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int c = 0; c < conv_pkg::buffers_num; c++) begin
            tap_col[c] = {1'b0, rd_col} + (conv_pkg::col_width+1)'(c);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int r = 0; r < conv_pkg::buffers_num; r++) begin
                for (int c = 0; c < conv_pkg::buffers_num; c++) begin
                    // row_len is 2**col_width, msb set means past the row end
                    window.pix[r][c] <= tap_col[c][conv_pkg::col_width] ? '0 :
                                        mem[r][tap_col[c][conv_pkg::col_width-1:0]];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= rd_en;  // window lands one cycle after the read
        end
    end

endmodule

// File: hw/mac_array.sv
`timescale 1ns/1ps

module mac_array (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wgt_we,
    input  conv_pkg::wgt_wr_t              wgt_wr,
    input  logic                           busy,
    input  conv_pkg::window_t              window,
    input  logic                           win_valid,
    input  logic [1:0]                     k,
    input  logic [conv_pkg::col_width-1:0] rd_index,
    output conv_pkg::result_t              res,
    output logic                           res_valid
);

    logic signed [conv_pkg::weight_width-1:0] wgt [conv_pkg::buffers_num][conv_pkg::buffers_num];
    logic signed [conv_pkg::acc_width-1:0] tap    [conv_pkg::buffers_num][conv_pkg::buffers_num];
    logic signed [conv_pkg::acc_width-1:0] prod_q [conv_pkg::buffers_num][conv_pkg::buffers_num];
    logic signed [conv_pkg::acc_width-1:0] sum;
    logic [conv_pkg::col_width-1:0] idx_win;  // index aligned with window
    logic [conv_pkg::col_width-1:0] idx_s1;   // index aligned with prod_q
    logic                           valid_s1;

    // kernel weights, loaded only between runs
    always_ff @(posedge clk) begin
        if (wgt_we && !busy && (wgt_wr.row < 2'(conv_pkg::buffers_num))
            && (wgt_wr.col < 2'(conv_pkg::buffers_num))) begin
            wgt[wgt_wr.row][wgt_wr.col] <= wgt_wr.data;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 1, masked products
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int r = 0; r < conv_pkg::buffers_num; r++) begin
            for (int c = 0; c < conv_pkg::buffers_num; c++) begin
                if ((2'(r) < k) && (2'(c) < k)) begin
                    // unsigned pixel times signed weight
                    tap[r][c] = $signed({{(conv_pkg::acc_width-conv_pkg::pixel_width){1'b0}},
                                         window.pix[r][c]}) * conv_pkg::acc_width'(wgt[r][c]);
                end else begin
                    tap[r][c] = '0;  // outside the k x k kernel
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        prod_q  <= tap;
        idx_win <= rd_index;  // read index, one cycle late like the window
        idx_s1  <= idx_win;
    end

    ////////////////////////////////////////////////////////////
    // stage 2, adder tree
    ////////////////////////////////////////////////////////////
    always_comb begin
        sum = '0;
        for (int r = 0; r < conv_pkg::buffers_num; r++) begin
            for (int c = 0; c < conv_pkg::buffers_num; c++) begin
                sum = sum + prod_q[r][c];
            end
        end
    end

    always_ff @(posedge clk) begin
        res.index <= idx_s1;
        res.value <= sum;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            valid_s1  <= win_valid;
            res_valid <= valid_s1;  // two cycles after win_valid
        end
    end

endmodule

// File: hw/window_sequencer.sv
`timescale 1ns/1ps

module window_sequencer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           en,
    input  conv_pkg::conv_cfg_t            cfg,
    input  logic                           res_valid,
    output logic                           rd_en,
    output logic [conv_pkg::col_width-1:0] rd_col,
    output logic [conv_pkg::col_width-1:0] rd_index,
    output conv_pkg::conv_cfg_t            cfg_q,
    output logic                           busy,
    output logic                           done,
    output logic                           start
);

    conv_pkg::seq_state_t         state;
    logic [conv_pkg::col_width:0] wb_count;    // writebacks seen this run
    logic [conv_pkg::col_width:0] last_index;  // ox - 1
    logic                         accept;

    // start only from idle, and an empty row is not a run
    assign accept     = (state == conv_pkg::seq_idle) && en && (cfg.ox != '0);
    assign last_index = cfg_q.ox - (conv_pkg::col_width+1)'(1);

    ////////////////////////////////////////////////////////////
    // config latch
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            cfg_q <= cfg;
        end
    end

    ////////////////////////////////////////////////////////////
    // run FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= conv_pkg::seq_idle;
            rd_index <= '0;
            wb_count <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (res_valid) begin
                wb_count <= wb_count + (conv_pkg::col_width+1)'(1);
            end
            case (state)
                conv_pkg::seq_idle: begin
                    if (accept) begin
                        state    <= conv_pkg::seq_run;
                        rd_index <= '0;
                        wb_count <= '0;
                    end
                end
                conv_pkg::seq_run: begin
                    // one window read per cycle
                    if ({1'b0, rd_index} == last_index) begin
                        state <= conv_pkg::seq_flush;
                    end else begin
                        rd_index <= rd_index + conv_pkg::col_width'(1);
                    end
                end
                conv_pkg::seq_flush: begin
                    // last result lands this cycle, busy drops with done
                    if (res_valid && (wb_count == last_index)) begin
                        state <= conv_pkg::seq_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= conv_pkg::seq_idle;
            endcase
        end
    end

    assign busy   = (state != conv_pkg::seq_idle);
    assign rd_en  = (state == conv_pkg::seq_run);
    assign rd_col = rd_index * {3'b000, cfg_q.s};  // base column x*s
    assign start  = rd_en && (rd_index == '0);     // first read of a run

endmodule

// File: src.f
hw/conv_pkg.sv
hw/line_buffers.sv
hw/window_sequencer.sv
hw/mac_array.sv
hw/channel_out_buffer.sv
hw/conv_datapath_front.sv
verification/conv_datapath_front_assert.sv
verification/conv_datapath_front_tb.sv

// File: verification/conv_datapath_front_assert.sv
`timescale 1ns/1ps

module conv_datapath_front_assert (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic done,
    input logic out_valid,
    input logic channel_out_en
);

    // done closes a run, so busy was up the cycle before
    done_in_run: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
        else $error("done seen without a run in progress");

    // a run ends only through done
    busy_drop: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
        else $error("busy fell without done");

    // drain data trails its strobe by one cycle
    drain_lag: assert property (@(posedge clk) disable iff (rst)
                                out_valid |-> $past(channel_out_en))
        else $error("out_valid without channel_out_en the cycle before");

endmodule

bind conv_datapath_front conv_datapath_front_assert i_conv_datapath_front_assert (
    .clk            (clk),
    .rst            (rst),
    .busy           (busy),
    .done           (done),
    .out_valid      (out_valid),
    .channel_out_en (channel_out_en)
);

// File: verification/conv_datapath_front_tb.sv
`timescale 1ns/1ps

module conv_datapath_front_tb;

    localparam int n_tests     = 6;
    localparam int test_cycles = 250;  // budget per test for the watchdog

    logic                                  clk;
    logic                                  rst;
    conv_pkg::conv_cfg_t                   cfg;
    logic                                  en;
    conv_pkg::pix_wr_t                     pix_wr;
    logic                                  pix_we;
    conv_pkg::wgt_wr_t                     wgt_wr;
    logic                                  wgt_we;
    logic                                  channel_out_en;
    logic                                  channel_out_reset;
    logic                                  busy;
    logic                                  done;
    logic                                  out_valid;
    logic [conv_pkg::col_width-1:0]        out_index;
    logic signed [conv_pkg::acc_width-1:0] out_value;

    int          pix_m [3][32];  // model copy of the line buffers
    int          wgt_m [3][3];   // model copy of the kernel
    logic [15:0] lfsr;
    string       test_name;
    int          cur_k, cur_s;    // config of the run being drained
    int          exp_idx;         // next index expected from the drain
    int          drained;
    int          test_errs;
    int          tests_run, tests_failed;

    conv_datapath_front i_conv_datapath_front (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////
    function automatic bit lfsr_step();
        bit fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // taps 16 14 13 11
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step());  // one step per bit
        end
        return v;
    endfunction

    // output x = sum of the k x k window products, zero past column 31
    function automatic int ref_conv(input int x, input int k, input int s);
        int sum;
        int col;
        sum = 0;
        for (int r = 0; r < k; r++) begin
            for (int c = 0; c < k; c++) begin
                col = x * s + c;
                if (col < 32) begin
                    sum += pix_m[r][col] * wgt_m[r][c];
                end
            end
        end
        return sum;
    endfunction

    ////////////////////////////////////////////////////////////
    // drive tasks, all on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic load_data(input bit random);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 32; c++) begin
                pix_m[r][c] = random ? rand_bits(8) : (r * 32 + c);  // ramp by default
                pix_wr = '{row: 2'(r), col: 5'(c), data: 8'(pix_m[r][c])};
                pix_we = 1'b1;
                @(negedge clk);
            end
        end
        pix_we = 1'b0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                wgt_m[r][c] = random ? (rand_bits(8) - 128) : (r * 3 + c - 4);  // -4..4
                wgt_wr = '{row: 2'(r), col: 2'(c), data: 8'(wgt_m[r][c])};
                wgt_we = 1'b1;
                @(negedge clk);
            end
        end
        wgt_we = 1'b0;
    endtask

    // start a row, optionally poke the inputs while busy, then wait on done
    task automatic run_conv(input int k, input int s, input int ox, input bit disturb);
        int waited;
        cur_k = k;
        cur_s = s;
        exp_idx = 0;
        cfg = '{k: 2'(k), s: 2'(s), ox: 6'(ox)};
        en = 1'b1;
        @(negedge clk);
        en = 1'b0;
        assert (busy) else begin
            $display("ERROR %s: busy did not rise after start", test_name);
            test_errs++;
        end
        waited = 0;
        while (!done && waited < ox + 10) begin
            if (disturb && busy) begin
                // column just ahead of the read, so a taken write would show
                pix_wr = '{row: 2'(waited % 3), col: 5'(waited + 2), data: 8'hff};
                pix_we = 1'b1;
                en = (waited == 2);  // second start mid run
                cfg.k = 2'd1;
            end
            @(negedge clk);
            pix_we = 1'b0;
            en = 1'b0;
            waited++;
        end
        assert (done) else begin
            $display("ERROR %s: done did not arrive after start", test_name);
            test_errs++;
        end
        assert (!busy) else begin
            $display("ERROR %s: busy still high in the done cycle", test_name);
            test_errs++;
        end
    endtask

    task automatic drain(input int n);
        channel_out_en = 1'b1;
        repeat (n) @(negedge clk);
        channel_out_en = 1'b0;
        repeat (2) @(negedge clk);  // last out_valid lands after the strobe
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
        drained   = 0;
        exp_idx   = 0;
    endtask

    task automatic finish_test(input int n_expected);
        assert (drained == n_expected) else begin
            $display("MISMATCH %s count: expected %0d, actual %0d",
                     test_name, n_expected, drained);
            test_errs++;
        end
        $display("test %-20s %s  outputs %0d  errors %0d", test_name,
                 (test_errs == 0) ? "pass" : "fail", drained, test_errs);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // checker, samples outputs mid cycle
    ////////////////////////////////////////////////////////////
    always @(negedge clk) begin : compare_drain
        int exp_val;
        if (!rst && out_valid) begin
            exp_val = ref_conv(exp_idx, cur_k, cur_s);
            assert (int'(out_index) == exp_idx) else begin
                $display("MISMATCH %s index: expected %0d, actual %0d",
                         test_name, exp_idx, out_index);
                test_errs++;
            end
            assert (int'(out_value) == exp_val) else begin
                $display("MISMATCH %s value[%0d]: expected %0d, actual %0d",
                         test_name, exp_idx, exp_val, out_value);
                test_errs++;
            end
            exp_idx++;
            drained++;
        end
    end

    initial begin
        repeat (n_tests * test_cycles) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles", n_tests * test_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        int k, s, ox, total;
        rst = 1'b1;
        cfg = '0;
        en = 1'b0;
        pix_wr = '0;
        pix_we = 1'b0;
        wgt_wr = '0;
        wgt_we = 1'b0;
        channel_out_en = 1'b0;
        channel_out_reset = 1'b0;
        lfsr = 16'd57758;
        tests_run = 0;
        tests_failed = 0;
        begin_test("idle");
        repeat (5) @(negedge clk);
        rst = 1'b0;

        begin_test("k3_s1_ox30");
        load_data(1'b0);  // ramp pixels, mixed-sign kernel
        run_conv(3, 1, 30, 1'b0);
        drain(30);
        finish_test(30);

        begin_test("k2_s2_ox16");  // outer taps still hold nonzero weights
        run_conv(2, 2, 16, 1'b0);
        drain(16);
        finish_test(16);

        begin_test("k1_s1_ox32");
        run_conv(1, 1, 32, 1'b0);
        drain(32);
        finish_test(32);

        begin_test("random_x3");
        total = 0;
        for (int i = 0; i < 3; i++) begin
            load_data(1'b1);
            k  = rand_bits(2) % 3 + 1;
            s  = rand_bits(1) + 1;
            ox = (s == 2) ? rand_bits(4) + 1 : rand_bits(5) + 1;  // base column stays < 32
            run_conv(k, s, ox, 1'b0);
            drain(ox);
            total += ox;
        end
        finish_test(total);

        begin_test("drain_restart");
        run_conv(3, 1, 20, 1'b0);
        drain(8);
        channel_out_reset = 1'b1;
        @(negedge clk);
        channel_out_reset = 1'b0;
        exp_idx = 0;  // drain starts over at index 0
        drain(20);
        finish_test(28);

        begin_test("writes_while_busy");
        run_conv(2, 1, 24, 1'b1);
        drain(24);
        finish_test(24);

        $display("tests %0d  passed %0d  failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
